// File: credit_link.f
hdl/credit_link_cfg_pkg.sv
hdl/credit_link_types_pkg.sv
hdl/credit_counter.sv
hdl/credit_sender.sv
hdl/ram_flops_1r1w.sv
hdl/fifo_ctrl_push_credit.sv
hdl/fifo_flops_push_credit.sv
hdl/credit_link_top.sv
dv/credit_link_tb.sv

// File: Bender.yml
package:
  name: credit_link

sources:
  # Packages first, then the design from the leaves up
  - hdl/credit_link_cfg_pkg.sv
  - hdl/credit_link_types_pkg.sv
  - hdl/credit_counter.sv
  - hdl/credit_sender.sv
  - hdl/ram_flops_1r1w.sv
  - hdl/fifo_ctrl_push_credit.sv
  - hdl/fifo_flops_push_credit.sv
  - hdl/credit_link_top.sv
  - target: test
    files:
      - dv/credit_link_tb.sv

// File: dv/credit_link_tb.sv
`timescale 1ns/1ns

/* Credit link testbench
   Directed tests of credit release, bypass, back-pressure, stall, withhold and a random stream */
module credit_link_tb;
  import credit_link_cfg_pkg::*;
  import credit_link_types_pkg::*;

  logic                clk;
  logic                rst_n;
  logic                src_valid;
  flit_t               src_flit;
  logic                src_accept;
  logic                pop_ready;
  logic                pop_valid;
  flit_t               pop_flit;
  logic                credit_stall;
  logic [CREDIT_W-1:0] credit_withhold;
  fifo_status_t        status;
  logic [CREDIT_W-1:0] sender_credits;

  integer seed = 32'hcce8_e0ed;
  // Reference model, every accepted flit in push order
  flit_t  model [$];
  int     pop_count = 0;

  credit_link_top i_credit_link_top (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      abort_run();
    end
  endtask

  // Inputs change a short delay after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic random_flit(output flit_t f);
    logic [31:0] r;
    r = $random(seed);
    f = r[20:0];
  endtask

  task automatic wait_credits(input int expected, input int limit);
    int cycles = 0;
    @(negedge clk);
    while (sender_credits != expected) begin
      cycles++;
      if (cycles > limit) begin
        $display("Timeout: sender credits never reached %0d", expected);
        abort_run();
      end
      @(negedge clk);
    end
  endtask

  // Credits must sit at one value for a number of cycles
  task automatic hold_credits(input int expected, input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_value("sender_credits", sender_credits, expected);
    end
  endtask

  // Offers fresh flits until n of them are accepted, pop_ready is left as the caller set it
  task automatic push_flits(input int n, input int limit);
    int accepted = 0;
    int cycles = 0;
    flit_t f;
    random_flit(f);
    while (accepted < n) begin
      next_cycle();
      src_valid = 1'b1;
      src_flit = f;
      @(negedge clk);
      if (src_accept) begin
        accepted++;
        random_flit(f);
      end
      cycles++;
      if (cycles > limit) begin
        $display("Timeout: the sender stopped accepting flits");
        abort_run();
      end
    end
    next_cycle();
    src_valid = 1'b0;
  endtask

  task automatic drain_fifo(input int limit);
    int cycles = 0;
    next_cycle();
    src_valid = 1'b0;
    pop_ready = 1'b1;
    @(negedge clk);
    while (!status.empty) begin
      cycles++;
      if (cycles > limit) begin
        $display("Timeout: the FIFO did not drain");
        abort_run();
      end
      @(negedge clk);
    end
  endtask

  // ----------------------------------------
  // Scoreboard
  // ----------------------------------------

  // A bypassed flit is pushed and popped in one cycle, so the push is recorded first
  always @(negedge clk) begin : scoreboard
    flit_t head;
    if (rst_n) begin
      if (src_accept) begin
        model.push_back(src_flit);
      end
      if (pop_valid && pop_ready) begin
        if (model.size() == 0) begin
          $display("A pop transfer happened with no flit expected");
          abort_run();
        end else begin
          head = model.pop_front();
          check_value("pop_flit", pop_flit, head);
          pop_count++;
        end
      end
    end
  end

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------

  task automatic test_reset_release();
    // src_valid is already high here and the sender holds no credit yet
    @(negedge clk);
    check_value("pop_valid", pop_valid, 0);
    check_value("src_accept", src_accept, 0);
    check_value("status.empty", status.empty, 1);
    check_value("status.items", status.items, 0);
    check_value("status.slots", status.slots, DEPTH);
    check_value("sender_credits", sender_credits, 0);
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    src_valid = 1'b0;
    wait_credits(DEPTH, 2 * DEPTH + 4);
    hold_credits(DEPTH, 5);
  endtask

  task automatic test_bypass();
    flit_t f;
    random_flit(f);
    next_cycle();
    pop_ready = 1'b1;
    src_valid = 1'b1;
    src_flit = f;
    @(negedge clk);
    check_value("src_accept", src_accept, 1);
    check_value("pop_valid", pop_valid, 1);
    check_value("pop_flit", pop_flit, f);
    next_cycle();
    src_valid = 1'b0;
    @(negedge clk);
    check_value("status.items", status.items, 0);
    wait_credits(DEPTH, 10);
  endtask

  task automatic test_fill_drain();
    int accepted = 0;
    int popped;
    flit_t f;
    for (int i = 0; i < DEPTH + 2; i++) begin
      random_flit(f);
      next_cycle();
      pop_ready = 1'b0;
      src_valid = 1'b1;
      src_flit = f;
      @(negedge clk);
      if (src_accept) begin
        accepted++;
      end
    end
    check_value("accepted pushes", accepted, DEPTH);
    // Still offering, but no credit is left
    next_cycle();
    @(negedge clk);
    check_value("src_accept", src_accept, 0);
    check_value("status.full", status.full, 1);
    check_value("status.slots", status.slots, 0);
    check_value("status.items", status.items, DEPTH);
    popped = pop_count;
    drain_fifo(2 * DEPTH);
    next_cycle();
    check_value("drained flits", pop_count - popped, DEPTH);
    wait_credits(DEPTH, 2 * DEPTH + 4);
  endtask

  task automatic test_stall();
    next_cycle();
    credit_stall = 1'b1;
    pop_ready = 1'b1;
    push_flits(2, 10);
    hold_credits(DEPTH - 2, 5);
    next_cycle();
    credit_stall = 1'b0;
    wait_credits(DEPTH, 10);
  endtask

  task automatic test_withhold();
    next_cycle();
    credit_withhold = CREDIT_W'(2);
    credit_stall = 1'b1;
    pop_ready = 1'b0;
    push_flits(DEPTH, 20);
    drain_fifo(2 * DEPTH);
    next_cycle();
    credit_stall = 1'b0;
    // Two credits stay parked in the FIFO's release counter
    wait_credits(DEPTH - 2, 10);
    hold_credits(DEPTH - 2, 5);
    next_cycle();
    credit_withhold = '0;
    wait_credits(DEPTH, 10);
  endtask

  task automatic test_random_stream();
    int accepted = 0;
    int cycles = 0;
    logic [31:0] r;
    flit_t f;
    random_flit(f);
    while (accepted < 200) begin
      r = $random(seed);
      next_cycle();
      src_valid = r[0];
      pop_ready = r[1];
      src_flit = f;
      @(negedge clk);
      if (src_accept) begin
        accepted++;
        random_flit(f);
      end
      cycles++;
      if (cycles > 4000) begin
        $display("Timeout: the random stream did not finish");
        abort_run();
      end
    end
    drain_fifo(4 * DEPTH);
    next_cycle();
    check_value("model queue size", model.size(), 0);
    wait_credits(DEPTH, 2 * DEPTH + 4);
  endtask

  initial begin
    rst_n = 1'b0;
    src_valid = 1'b1;
    src_flit = '0;
    pop_ready = 1'b0;
    credit_stall = 1'b0;
    credit_withhold = '0;
    test_reset_release();
    test_bypass();
    test_fill_drain();
    test_stall();
    test_withhold();
    test_random_stream();
    $display("Test OK");
    $finish;
  end

endmodule : credit_link_tb

// File: hdl/credit_link_top.sv
`timescale 1ns/1ns

/* Credit link top level
   Credit sender on the source side feeding the credit push FIFO */
module credit_link_top (
  input  logic                                    clk,
  input  logic                                    rst_n,
  // Source side
  input  logic                                    src_valid,
  input  credit_link_types_pkg::flit_t             src_flit,
  output logic                                    src_accept,
  // Sink side
  input  logic                                    pop_ready,
  output logic                                    pop_valid,
  output credit_link_types_pkg::flit_t             pop_flit,
  // Credit return control, both level inputs
  input  logic                                    credit_stall,
  input  logic [credit_link_cfg_pkg::CREDIT_W-1:0] credit_withhold,
  // Observation
  output credit_link_types_pkg::fifo_status_t      status,
  output logic [credit_link_cfg_pkg::CREDIT_W-1:0] sender_credits
);
  import credit_link_types_pkg::*;

  // The link between sender and FIFO, pushes one way and credits back
  logic  push_valid;
  flit_t push_flit;
  logic  push_credit;

  credit_sender i_sender (
    .clk,
    .rst_n,
    .src_valid,
    .src_flit,
    .src_accept,
    .push_credit,
    .push_valid,
    .push_flit,
    .credits     (sender_credits)
  );

  fifo_flops_push_credit i_fifo (
    .clk,
    .rst_n,
    .push_valid,
    .push_flit,
    .push_credit,
    .credit_stall,
    .credit_withhold,
    .pop_ready,
    .pop_valid,
    .pop_flit,
    .status
  );

endmodule : credit_link_top

// File: hdl/fifo_flops_push_credit.sv
`timescale 1ns/1ns

/* Credit push FIFO with internal flop RAM
   Joins the FIFO controller to its storage */
module fifo_flops_push_credit (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    push_valid,
  input  credit_link_types_pkg::flit_t             push_flit,
  output logic                                    push_credit,
  input  logic                                    credit_stall,
  input  logic [credit_link_cfg_pkg::CREDIT_W-1:0] credit_withhold,
  input  logic                                    pop_ready,
  output logic                                    pop_valid,
  output credit_link_types_pkg::flit_t             pop_flit,
  output credit_link_types_pkg::fifo_status_t      status
);
  import credit_link_types_pkg::*;

  // Requests from the controller and the read data coming back
  ram_wr_t ram_wr;
  ram_rd_t ram_rd;
  flit_t   ram_rd_flit;

  // Control, bypass and credit release
  fifo_ctrl_push_credit i_ctrl (
    .clk,
    .rst_n,
    .push_valid,
    .push_flit,
    .push_credit,
    .credit_stall,
    .credit_withhold,
    .pop_ready,
    .pop_valid,
    .pop_flit,
    .status,
    .ram_wr,
    .ram_rd,
    .ram_rd_flit
  );

  // Storage, written at the edge and read in the same cycle
  ram_flops_1r1w i_ram (
    .clk,
    .rst_n,
    .wr      (ram_wr),
    .rd      (ram_rd),
    .rd_flit (ram_rd_flit)
  );

endmodule : fifo_flops_push_credit

// File: hdl/fifo_ctrl_push_credit.sv
`timescale 1ns/1ns

/* FIFO controller with credit push and ready/valid pop
   Pointers, occupancy, empty bypass, credit release and the flop RAM requests */
module fifo_ctrl_push_credit (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    push_valid,
  input  credit_link_types_pkg::flit_t             push_flit,
  output logic                                    push_credit,
  input  logic                                    credit_stall,
  input  logic [credit_link_cfg_pkg::CREDIT_W-1:0] credit_withhold,
  input  logic                                    pop_ready,
  output logic                                    pop_valid,
  output credit_link_types_pkg::flit_t             pop_flit,
  output credit_link_types_pkg::fifo_status_t      status,
  output credit_link_types_pkg::ram_wr_t           ram_wr,
  output credit_link_types_pkg::ram_rd_t           ram_rd,
  input  credit_link_types_pkg::flit_t             ram_rd_flit
);
  import credit_link_cfg_pkg::*;
  import credit_link_types_pkg::*;

  logic [ADDR_W-1:0]  wr_ptr;
  logic [ADDR_W-1:0]  rd_ptr;
  logic [COUNT_W-1:0] items_q;
  logic               empty;
  logic               bypass_sel;
  logic               pop_xfer;
  logic               bypass_xfer;
  logic               ram_push;
  logic               ram_pop;
  logic               credit_available;
  logic               release_en;

  // Pointer step with a wrap after the last entry
  function automatic logic [ADDR_W-1:0] ptr_step(input logic [ADDR_W-1:0] ptr);
    logic [ADDR_W-1:0] nxt;
    if (ptr == ADDR_W'(DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + ADDR_W'(1);
    end
    return nxt;
  endfunction

  // ----------------------------------------
  // Pop port and bypass
  // ----------------------------------------

  assign empty = (items_q == '0);

  // While the RAM is empty the pop port looks straight at the push side
  assign bypass_sel = ENABLE_BYPASS && empty;

  // With entries stored, the head of the RAM is always on offer
  assign pop_valid = bypass_sel ? push_valid : !empty;
  assign pop_flit = bypass_sel ? push_flit : ram_rd_flit;

  assign pop_xfer = pop_valid && pop_ready;

  // A flit that cuts through and is taken at once never touches the RAM
  assign bypass_xfer = bypass_sel && pop_xfer;

  // Pushes are never refused here, the credit loop keeps them in bounds
  assign ram_push = push_valid && !bypass_xfer;
  assign ram_pop = pop_xfer && !bypass_xfer;

  // ----------------------------------------
  // Flop RAM requests
  // ----------------------------------------

  always_comb begin
    ram_wr.valid = ram_push;
    ram_wr.addr = wr_ptr;
    ram_wr.flit = push_flit;
    // The read address tracks the head so ram_rd_flit is the next flit to pop
    ram_rd.valid = !empty;
    ram_rd.addr = rd_ptr;
  end

  // ----------------------------------------
  // Pointers and occupancy
  // ----------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (ram_push) begin
        wr_ptr <= ptr_step(wr_ptr);
      end
      if (ram_pop) begin
        rd_ptr <= ptr_step(rd_ptr);
      end
    end
  end

  // A write and a read in the same cycle leave the item count as it is
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      items_q <= '0;
    end else if (ram_push && !ram_pop) begin
      items_q <= items_q + COUNT_W'(1);
    end else if (ram_pop && !ram_push) begin
      items_q <= items_q - COUNT_W'(1);
    end
  end

  // Status is taken from the registered count only
  always_comb begin
    status.items = items_q;
    status.slots = COUNT_W'(DEPTH) - items_q;
    status.full = (items_q == COUNT_W'(DEPTH));
    status.empty = empty;
  end

  // ----------------------------------------
  // Credit release
  // ----------------------------------------

  // Credit release starts on the first edge after reset is released
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      release_en <= 1'b0;
    end else begin
      release_en <= 1'b1;
    end
  end

  // Holds the credits not yet handed to the sender, one full FIFO's worth at reset
  // Every pop frees a slot and earns a credit back
  credit_counter i_release_counter (
    .clk,
    .rst_n,
    .incr        (pop_xfer),
    .decr        (push_credit),
    .reset_value (CREDIT_W'(DEPTH)),
    .withhold    (credit_withhold),
    .count       (),
    .available   (credit_available)
  );

  // One credit per cycle at most, held back while the stall is up
  assign push_credit = release_en && credit_available && !credit_stall;

endmodule : fifo_ctrl_push_credit

// File: hdl/ram_flops_1r1w.sv
`timescale 1ns/1ns

/* Flop RAM, one write and one read port
   Write at the clock edge, read returns the addressed entry in the same cycle */
module ram_flops_1r1w (
  input  logic                           clk,
  input  logic                           rst_n,
  input  credit_link_types_pkg::ram_wr_t wr,
  input  credit_link_types_pkg::ram_rd_t rd,
  output credit_link_types_pkg::flit_t   rd_flit
);
  import credit_link_cfg_pkg::*;
  import credit_link_types_pkg::*;

  // Storage array, one flit per FIFO entry
  flit_t mem [DEPTH];

  // ----------------------------------------
  // Write port
  // ----------------------------------------

  // Entries are written only once reset has been released
  // Contents are undefined until the FIFO first writes them
  always_ff @(posedge clk) begin
    if (rst_n && wr.valid) begin
      mem[wr.addr] <= wr.flit;
    end
  end

  // ----------------------------------------
  // Read port
  // ----------------------------------------

  // Unregistered read so the FIFO head is visible without a cycle of latency
  // An idle read port returns zero instead of a stale entry
  always_comb begin
    if (rd.valid) begin
      rd_flit = mem[rd.addr];
    end else begin
      rd_flit = '0;
    end
  end

endmodule : ram_flops_1r1w

// File: hdl/credit_sender.sv
`timescale 1ns/1ns

/* Credit sender
   Holds the credits returned by the FIFO and lets the source push only against one */
module credit_sender (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    src_valid,
  input  credit_link_types_pkg::flit_t             src_flit,
  output logic                                    src_accept,
  input  logic                                    push_credit,
  output logic                                    push_valid,
  output credit_link_types_pkg::flit_t             push_flit,
  output logic [credit_link_cfg_pkg::CREDIT_W-1:0] credits
);

  logic credit_available;

  // ----------------------------------------
  // Credit store
  // ----------------------------------------

  // The sender starts empty and owns only what the FIFO hands back
  // Nothing is withheld on this side, every held credit may be spent
  credit_counter i_credit_store (
    .clk,
    .rst_n,
    .incr        (push_credit),
    .decr        (push_valid),
    .reset_value ('0),
    .withhold    ('0),
    .count       (credits),
    .available   (credit_available)
  );

  // ----------------------------------------
  // Push gating
  // ----------------------------------------

  // A push is granted only against a credit already held
  // A credit that arrives in this cycle is counted at the edge and spent next cycle
  assign src_accept = src_valid && credit_available;

  // Every granted push goes onto the link and uses up one credit
  assign push_valid = src_accept;

  // The flit passes through unchanged
  assign push_flit = src_flit;

endmodule : credit_sender

// File: hdl/credit_counter.sv
`timescale 1ns/1ns

/* Credit counter
   Saturating up/down credit count with a load value at reset and a withhold compare */
module credit_counter (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    incr,
  input  logic                                    decr,
  input  logic [credit_link_cfg_pkg::CREDIT_W-1:0] reset_value,
  input  logic [credit_link_cfg_pkg::CREDIT_W-1:0] withhold,
  output logic [credit_link_cfg_pkg::CREDIT_W-1:0] count,
  output logic                                    available
);
  import credit_link_cfg_pkg::*;

  logic [CREDIT_W-1:0] count_next;
  logic                at_max;
  logic                at_zero;

  // ----------------------------------------
  // Next count
  // ----------------------------------------

  // Limits of the counter, it never wraps in either direction
  assign at_max = (count == {CREDIT_W{1'b1}});
  assign at_zero = (count == '0);

  // A credit coming in and a credit going out in the same cycle cancel
  always_comb begin
    count_next = count;
    if (incr && !decr && !at_max) begin
      count_next = count + CREDIT_W'(1);
    end else if (decr && !incr && !at_zero) begin
      count_next = count - CREDIT_W'(1);
    end
  end

  // ----------------------------------------
  // Count register
  // ----------------------------------------

  // The count loads its start value for as long as reset is held
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= reset_value;
    end else begin
      count <= count_next;
    end
  end

  // Credits up to the withhold level stay parked in the counter
  // Only the ones above it may be handed out
  assign available = (count > withhold);

endmodule : credit_counter

// File: hdl/credit_link_types_pkg.sv
/* Credit link types
   Payload flit, flop RAM request words and the FIFO status word */
package credit_link_types_pkg;

  // ----------------------------------------
  // Payload
  // ----------------------------------------

  // One flit of the link, 21 bits in total
  typedef struct packed {
    // Stream or transaction tag chosen by the source
    logic [3:0]  tag;
    // Payload word
    logic [15:0] data;
    // Marks the final flit of a packet
    logic        last;
  } flit_t;

  // ----------------------------------------
  // Flop RAM requests
  // ----------------------------------------

  // Write request, taken by the RAM at the clock edge
  typedef struct packed {
    logic                                  valid;
    logic [credit_link_cfg_pkg::ADDR_W-1:0] addr;
    flit_t                                 flit;
  } ram_wr_t;

  // Read request, the addressed flit comes back in the same cycle
  typedef struct packed {
    logic                                  valid;
    logic [credit_link_cfg_pkg::ADDR_W-1:0] addr;
  } ram_rd_t;

  // ----------------------------------------
  // Status
  // ----------------------------------------

  // Occupancy seen from both sides of the FIFO
  typedef struct packed {
    logic [credit_link_cfg_pkg::COUNT_W-1:0] items;
    logic [credit_link_cfg_pkg::COUNT_W-1:0] slots;
    logic                                   full;
    logic                                   empty;
  } fifo_status_t;

endpackage : credit_link_types_pkg

// File: hdl/credit_link_cfg_pkg.sv
/* Credit link sizing
   FIFO depth, derived field widths and the bypass choice */
package credit_link_cfg_pkg;

  // ----------------------------------------
  // FIFO sizing
  // ----------------------------------------

  // Number of entries in the flop RAM
  localparam int DEPTH = 4;

  // Address into the flop RAM, enough to reach every entry
  localparam int ADDR_W = $clog2(DEPTH);

  // Items and slots must be able to hold the value DEPTH itself
  localparam int COUNT_W = $clog2(DEPTH + 1);

  // ----------------------------------------
  // Credit loop
  // ----------------------------------------

  // The largest credit count is DEPTH, so the credit width follows the count width
  localparam int CREDIT_W = $clog2(DEPTH + 1);

  // Push-to-pop cut-through when the FIFO is empty
  // With this set a push into an empty FIFO shows at the pop port in the same cycle
  localparam bit ENABLE_BYPASS = 1'b1;

endpackage : credit_link_cfg_pkg
